// ==== sources.f ====
verilog/csr_pkg.sv
verilog/csr_exception_regs.sv
verilog/csr_interrupt.sv
verilog/csr_timer.sv
verilog/csr_read_mux.sv
verilog/csr_unit.sv
tests/tb_csr_unit.sv

// ==== tests/csr_testdata.txt ====
// op csr_num mask value wait expected  (op 1 wr, 2 rd, 3 exc, 4 ertn, 5 int, 6 wait, 7 has_int, f end)
// exception rows: csr_num is ecode, mask is subcode, value is pc, expected is vaddr
2 0000 00000000 00000000 0 00000008
2 0004 00000000 00000000 0 00000000
2 0005 00000000 00000000 0 00000000
2 0042 00000000 00000000 0 ffffffff
2 0040 00000000 00000000 0 00000000
1 0030 ffffffff 12345678 0 00000000
1 0030 0000ffff aaaaaaaa 0 00000000
2 0030 00000000 00000000 0 1234aaaa
1 000c ffffffff 1c008040 0 00000000
1 000c 0000ffff 0000ffff 0 00000000
2 000c 00000000 00000000 0 1c00ffc0
1 0004 ffffffff ffffffff 0 00000000
2 0004 00000000 00000000 0 00001bff
1 0004 00000003 00000000 0 00000000
2 0004 00000000 00000000 0 00001bfc
1 0004 ffffffff 00000000 0 00000000
// exception entry and return
1 0000 ffffffff 00000007 0 00000000
2 0000 00000000 00000000 0 0000000f
3 000b 00000000 1c000100 0 00000000
2 0000 00000000 00000000 0 00000008
2 0001 00000000 00000000 0 00000007
2 0006 00000000 00000000 0 1c000100
2 0005 00000000 00000000 0 000b0000
4 0000 00000000 00000000 0 00000000
2 0000 00000000 00000000 0 0000000f
// badv capture
3 0008 00000000 1c000204 0 0badbad0
2 0007 00000000 00000000 0 1c000204
3 0009 00000000 1c000300 0 00001235
2 0007 00000000 00000000 0 00001235
3 0008 00000001 1c000400 0 00005678
2 0007 00000000 00000000 0 00005678
2 0005 00000000 00000000 0 00480000
3 000b 00000000 1c000500 0 11111111
2 0007 00000000 00000000 0 00005678
// interrupts
1 0004 ffffffff 00000008 0 00000000
1 0000 00000004 00000004 0 00000000
7 0000 00000000 00000000 0 00000000
5 0000 00000000 00000002 0 00000000
7 0000 00000000 00000000 0 00000001
2 0005 00000000 00000000 0 000b0008
1 0000 00000004 00000000 0 00000000
7 0000 00000000 00000000 0 00000000
1 0000 00000004 00000004 0 00000000
5 0000 00000000 00000000 0 00000000
7 0000 00000000 00000000 0 00000000
1 0004 ffffffff 00001000 0 00000000
5 0000 00000000 00000100 0 00000000
7 0000 00000000 00000000 0 00000001
2 0005 00000000 00000000 0 000b1000
5 0000 00000000 00000000 0 00000000
1 0004 ffffffff 00000800 0 00000000
// one-shot timer, initval 3
1 0041 ffffffff 0000000d 0 00000000
2 0042 00000000 00000000 0 0000000c
2 0041 00000000 00000000 0 0000000d
6 0000 00000000 00000000 3 00000000
2 0042 00000000 00000000 0 00000007
6 0000 00000000 00000000 6 00000000
2 0042 00000000 00000000 0 00000000
2 0042 00000000 00000000 0 ffffffff
2 0005 00000000 00000000 0 000b0800
7 0000 00000000 00000000 0 00000001
1 0044 00000000 00000001 0 00000000
2 0005 00000000 00000000 0 000b0800
1 0044 00000001 00000001 0 00000000
2 0005 00000000 00000000 0 000b0000
7 0000 00000000 00000000 0 00000000
// periodic timer, initval 2
1 0041 ffffffff 0000000b 0 00000000
2 0042 00000000 00000000 0 00000008
6 0000 00000000 00000000 6 00000000
2 0042 00000000 00000000 0 00000001
2 0042 00000000 00000000 0 00000000
2 0042 00000000 00000000 0 00000008
2 0042 00000000 00000000 0 00000007
2 0005 00000000 00000000 0 000b0800
1 0041 00000001 00000000 0 00000000
2 0042 00000000 00000000 0 00000004
6 0000 00000000 00000000 3 00000000
2 0042 00000000 00000000 0 00000004
1 0044 ffffffff 00000001 0 00000000
2 0005 00000000 00000000 0 000b0000
f 0000 00000000 00000000 0 00000000

// ==== tests/tb_csr_unit.sv ====
// csr unit testbench
`timescale 1ns/10ps

module tb_csr_unit;

    localparam int REC_WORDS   = 6;
    localparam int MAX_RECORDS = 256;
    localparam int CLK_PERIOD  = 100;

    // operation codes of the data file
    localparam logic [31:0] OP_WRITE  = 32'h1;
    localparam logic [31:0] OP_READ   = 32'h2;
    localparam logic [31:0] OP_EXCEPT = 32'h3;
    localparam logic [31:0] OP_ERTN   = 32'h4;
    localparam logic [31:0] OP_INT    = 32'h5;
    localparam logic [31:0] OP_WAIT   = 32'h6;
    localparam logic [31:0] OP_HASINT = 32'h7;
    localparam logic [31:0] OP_END    = 32'hf;

    logic                   clk;
    logic                   resetn;
    csr_pkg::csr_num_t      csr_num;
    logic                   csr_we;
    csr_pkg::csr_word_t     csr_wmask;
    csr_pkg::csr_word_t     csr_wvalue;
    csr_pkg::csr_word_t     csr_rvalue;
    logic                   wb_ex;
    csr_pkg::ecode_t        wb_ecode;
    csr_pkg::esubcode_t     wb_esubcode;
    csr_pkg::csr_word_t     wb_pc;
    csr_pkg::csr_word_t     wb_vaddr;
    logic                   ertn_flush;
    logic [7:0]             hw_int_in;
    logic                   ipi_int_in;
    logic                   has_int;

    logic [31:0] testdata [0:REC_WORDS*MAX_RECORDS-1];
    int          num_records;
    int          checks_done;
    longint      wait_total;
    longint      watchdog_ns;   // zero until the data is loaded

    csr_unit dut (
        .clk         (clk),
        .resetn      (resetn),
        .csr_num     (csr_num),
        .csr_we      (csr_we),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .csr_rvalue  (csr_rvalue),
        .wb_ex       (wb_ex),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .wb_vaddr    (wb_vaddr),
        .ertn_flush  (ertn_flush),
        .hw_int_in   (hw_int_in),
        .ipi_int_in  (ipi_int_in),
        .has_int     (has_int)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks_done++;
        if (actual !== expected) begin
            $display("CHECK FAILED: %s got 0x%08h expected 0x%08h", name, actual, expected);
            $display("Regression failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic load_testdata();
        int idx;
        $readmemh("tests/csr_testdata.txt", testdata);
        wait_total = 0;
        for (idx = 0; idx < MAX_RECORDS; idx++) begin
            if (testdata[idx*REC_WORDS] === OP_END)
                break;
            if ($isunknown(testdata[idx*REC_WORDS])) begin
                $display("test data record %0d has no valid operation code", idx);
                $display("Regression failed");
                $fatal(1, "bad test data");
            end
            wait_total += testdata[idx*REC_WORDS + 4];
        end
        if (idx == MAX_RECORDS) begin
            $display("test data has no end marker");
            $display("Regression failed");
            $fatal(1, "bad test data");
        end
        num_records = idx;
    endtask

    // each record is entered and left on a falling edge
    task automatic run_record(input int idx);
        logic [31:0] op;
        logic [31:0] num;
        logic [31:0] mask;
        logic [31:0] value;
        logic [31:0] wait_cnt;
        logic [31:0] expected;
        op       = testdata[idx*REC_WORDS];
        num      = testdata[idx*REC_WORDS + 1];
        mask     = testdata[idx*REC_WORDS + 2];
        value    = testdata[idx*REC_WORDS + 3];
        wait_cnt = testdata[idx*REC_WORDS + 4];
        expected = testdata[idx*REC_WORDS + 5];
        case (op)
            OP_WRITE: begin
                csr_num    = num[13:0];
                csr_wmask  = mask;
                csr_wvalue = value;
                csr_we     = 1'b1;
                @(negedge clk);
                csr_we     = 1'b0;
            end
            OP_READ: begin
                csr_num = num[13:0];
                #1;   // combinational read settles
                check_value($sformatf("csr_rvalue (csr 0x%03h)", num[13:0]),
                            csr_rvalue, expected);
                @(negedge clk);
            end
            OP_EXCEPT: begin
                wb_ecode    = num[5:0];
                wb_esubcode = mask[8:0];
                wb_pc       = value;
                wb_vaddr    = expected;   // vaddr shares the last column
                wb_ex       = 1'b1;
                @(negedge clk);
                wb_ex       = 1'b0;
            end
            OP_ERTN: begin
                ertn_flush = 1'b1;
                @(negedge clk);
                ertn_flush = 1'b0;
            end
            OP_INT: begin
                hw_int_in  = value[7:0];
                ipi_int_in = value[8];
                @(negedge clk);
            end
            OP_WAIT: begin
                repeat (wait_cnt) @(negedge clk);
            end
            OP_HASINT: begin
                #1;
                check_value("has_int", {31'b0, has_int}, expected);
                @(negedge clk);
            end
            default: begin
                $display("unknown operation code %0h in record %0d", op, idx);
                $display("Regression failed");
                $fatal(1, "bad operation code");
            end
        endcase
    endtask

    initial begin
        clk         = 1'b0;
        resetn      = 1'b0;
        csr_num     = '0;
        csr_we      = 1'b0;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        wb_ex       = 1'b0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        wb_pc       = '0;
        wb_vaddr    = '0;
        ertn_flush  = 1'b0;
        hw_int_in   = '0;
        ipi_int_in  = 1'b0;
        checks_done = 0;
        watchdog_ns = 0;

        load_testdata();
        // waits plus four cycles per record plus slack for reset
        watchdog_ns = (wait_total + 4 * num_records) * CLK_PERIOD + 100 * CLK_PERIOD;

        repeat (10) @(negedge clk);
        resetn = 1'b1;

        for (int i = 0; i < num_records; i++)
            run_record(i);

        if (checks_done > 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("no checks were run from the test data");
            $display("Regression failed");
            $fatal(1, "empty test sequence");
        end
    end

    initial begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("timeout: test sequence did not finish in %0d ns", watchdog_ns);
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== verilog/csr_unit.sv ====
// csr unit top level
`timescale 1ns/10ps

module csr_unit (
    input  logic                    clk,
    input  logic                    resetn,
    input  csr_pkg::csr_num_t       csr_num,
    input  logic                    csr_we,
    input  csr_pkg::csr_word_t      csr_wmask,
    input  csr_pkg::csr_word_t      csr_wvalue,
    output csr_pkg::csr_word_t      csr_rvalue,
    input  logic                    wb_ex,
    input  csr_pkg::ecode_t         wb_ecode,
    input  csr_pkg::esubcode_t      wb_esubcode,
    input  csr_pkg::csr_word_t      wb_pc,
    input  csr_pkg::csr_word_t      wb_vaddr,
    input  logic                    ertn_flush,
    input  logic [7:0]              hw_int_in,
    input  logic                    ipi_int_in,
    output logic                    has_int
);

    csr_pkg::plv_t          crmd_plv;
    logic                   crmd_ie;
    csr_pkg::plv_t          prmd_pplv;
    logic                   prmd_pie;
    csr_pkg::ecode_t        estat_ecode;
    csr_pkg::esubcode_t     estat_esubcode;
    csr_pkg::csr_word_t     era_pc;
    csr_pkg::csr_word_t     badv_vaddr;
    csr_pkg::eentry_va_t    eentry_va;
    csr_pkg::csr_word_t     save0;
    csr_pkg::csr_word_t     save1;
    csr_pkg::csr_word_t     save2;
    csr_pkg::csr_word_t     save3;
    csr_pkg::int_vec_t      ecfg_lie;
    csr_pkg::int_vec_t      estat_is;
    csr_pkg::csr_word_t     tid;
    logic                   tcfg_en;
    logic                   tcfg_periodic;
    csr_pkg::tcfg_initval_t tcfg_initval;
    csr_pkg::csr_word_t     tval;
    logic                   timer_expired;

    csr_exception_regs u_exception_regs (
        .clk            (clk),
        .resetn         (resetn),
        .csr_num        (csr_num),
        .csr_we         (csr_we),
        .csr_wmask      (csr_wmask),
        .csr_wvalue     (csr_wvalue),
        .wb_ex          (wb_ex),
        .ertn_flush     (ertn_flush),
        .wb_ecode       (wb_ecode),
        .wb_esubcode    (wb_esubcode),
        .wb_pc          (wb_pc),
        .wb_vaddr       (wb_vaddr),
        .crmd_plv       (crmd_plv),
        .crmd_ie        (crmd_ie),
        .prmd_pplv      (prmd_pplv),
        .prmd_pie       (prmd_pie),
        .estat_ecode    (estat_ecode),
        .estat_esubcode (estat_esubcode),
        .era_pc         (era_pc),
        .badv_vaddr     (badv_vaddr),
        .eentry_va      (eentry_va),
        .save0          (save0),
        .save1          (save1),
        .save2          (save2),
        .save3          (save3)
    );

    csr_interrupt u_interrupt (
        .clk           (clk),
        .resetn        (resetn),
        .csr_num       (csr_num),
        .csr_we        (csr_we),
        .csr_wmask     (csr_wmask),
        .csr_wvalue    (csr_wvalue),
        .hw_int_in     (hw_int_in),
        .ipi_int_in    (ipi_int_in),
        .crmd_ie       (crmd_ie),
        .timer_expired (timer_expired),
        .ecfg_lie      (ecfg_lie),
        .estat_is      (estat_is),
        .has_int       (has_int)
    );

    csr_timer u_timer (
        .clk           (clk),
        .resetn        (resetn),
        .csr_num       (csr_num),
        .csr_we        (csr_we),
        .csr_wmask     (csr_wmask),
        .csr_wvalue    (csr_wvalue),
        .tid           (tid),
        .tcfg_en       (tcfg_en),
        .tcfg_periodic (tcfg_periodic),
        .tcfg_initval  (tcfg_initval),
        .tval          (tval),
        .timer_expired (timer_expired)
    );

    csr_read_mux u_read_mux (
        .csr_num        (csr_num),
        .crmd_plv       (crmd_plv),
        .crmd_ie        (crmd_ie),
        .prmd_pplv      (prmd_pplv),
        .prmd_pie       (prmd_pie),
        .estat_ecode    (estat_ecode),
        .estat_esubcode (estat_esubcode),
        .era_pc         (era_pc),
        .badv_vaddr     (badv_vaddr),
        .eentry_va      (eentry_va),
        .save0          (save0),
        .save1          (save1),
        .save2          (save2),
        .save3          (save3),
        .ecfg_lie       (ecfg_lie),
        .estat_is       (estat_is),
        .tid            (tid),
        .tcfg_en        (tcfg_en),
        .tcfg_periodic  (tcfg_periodic),
        .tcfg_initval   (tcfg_initval),
        .tval           (tval),
        .csr_rvalue     (csr_rvalue)
    );

endmodule

// ==== verilog/csr_read_mux.sv ====
// csr read data select
`timescale 1ns/10ps

module csr_read_mux (
    input  csr_pkg::csr_num_t       csr_num,
    input  csr_pkg::plv_t           crmd_plv,
    input  logic                    crmd_ie,
    input  csr_pkg::plv_t           prmd_pplv,
    input  logic                    prmd_pie,
    input  csr_pkg::ecode_t         estat_ecode,
    input  csr_pkg::esubcode_t      estat_esubcode,
    input  csr_pkg::csr_word_t      era_pc,
    input  csr_pkg::csr_word_t      badv_vaddr,
    input  csr_pkg::eentry_va_t     eentry_va,
    input  csr_pkg::csr_word_t      save0,
    input  csr_pkg::csr_word_t      save1,
    input  csr_pkg::csr_word_t      save2,
    input  csr_pkg::csr_word_t      save3,
    input  csr_pkg::int_vec_t       ecfg_lie,
    input  csr_pkg::int_vec_t       estat_is,
    input  csr_pkg::csr_word_t      tid,
    input  logic                    tcfg_en,
    input  logic                    tcfg_periodic,
    input  csr_pkg::tcfg_initval_t  tcfg_initval,
    input  csr_pkg::csr_word_t      tval,
    output csr_pkg::csr_word_t      csr_rvalue
);

    always_comb begin
        case (csr_num)
            // datm, datf, pg zero and da fixed at one
            csr_pkg::CSR_CRMD:   csr_rvalue = {27'b0, 1'b1, crmd_ie, crmd_plv};
            csr_pkg::CSR_PRMD:   csr_rvalue = {29'b0, prmd_pie, prmd_pplv};
            csr_pkg::CSR_ECFG:   csr_rvalue = {19'b0, ecfg_lie};
            csr_pkg::CSR_ESTAT: begin
                csr_rvalue = {1'b0, estat_esubcode, estat_ecode, 3'b0, estat_is};
            end
            csr_pkg::CSR_ERA:    csr_rvalue = era_pc;
            csr_pkg::CSR_BADV:   csr_rvalue = badv_vaddr;
            csr_pkg::CSR_EENTRY: csr_rvalue = {eentry_va, 6'b0};   // 64-byte aligned
            csr_pkg::CSR_SAVE0:  csr_rvalue = save0;
            csr_pkg::CSR_SAVE1:  csr_rvalue = save1;
            csr_pkg::CSR_SAVE2:  csr_rvalue = save2;
            csr_pkg::CSR_SAVE3:  csr_rvalue = save3;
            csr_pkg::CSR_TID:    csr_rvalue = tid;
            csr_pkg::CSR_TCFG:   csr_rvalue = {tcfg_initval, tcfg_periodic, tcfg_en};
            csr_pkg::CSR_TVAL:   csr_rvalue = tval;
            // ticlr is write-only and falls through to zero
            default:             csr_rvalue = '0;
        endcase
    end

endmodule

// ==== verilog/csr_timer.sv ====
// constant timer
`timescale 1ns/10ps

module csr_timer (
    input  logic                    clk,
    input  logic                    resetn,
    input  csr_pkg::csr_num_t       csr_num,
    input  logic                    csr_we,
    input  csr_pkg::csr_word_t      csr_wmask,
    input  csr_pkg::csr_word_t      csr_wvalue,
    output csr_pkg::csr_word_t      tid,
    output logic                    tcfg_en,
    output logic                    tcfg_periodic,
    output csr_pkg::tcfg_initval_t  tcfg_initval,
    output csr_pkg::csr_word_t      tval,
    output logic                    timer_expired
);

    csr_pkg::csr_word_t tcfg_next;
    csr_pkg::csr_word_t timer_cnt;
    logic               tcfg_wr;

    assign tcfg_wr = csr_we && (csr_num == csr_pkg::CSR_TCFG);

    // tcfg as it will be after this cycle's write
    assign tcfg_next = csr_pkg::masked_write({tcfg_initval, tcfg_periodic, tcfg_en},
                                             csr_wmask, csr_wvalue);

    always_ff @(posedge clk) begin
        if (!resetn)
            tid <= '0;
        else if (csr_we && csr_num == csr_pkg::CSR_TID)
            tid <= csr_pkg::masked_write(tid, csr_wmask, csr_wvalue);
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            tcfg_en <= 1'b0;
        else if (tcfg_wr)
            tcfg_en <= tcfg_next[0];
    end

    always_ff @(posedge clk) begin
        if (tcfg_wr) begin
            tcfg_periodic <= tcfg_next[1];
            tcfg_initval  <= tcfg_next[31:2];
        end
    end

    // initval counts in units of four ticks
    always_ff @(posedge clk) begin
        if (!resetn) begin
            timer_cnt <= csr_pkg::TIMER_STOPPED;
        end else if (tcfg_wr && tcfg_next[0]) begin
            timer_cnt <= {tcfg_next[31:2], 2'b0};
        end else if (tcfg_en && timer_cnt != csr_pkg::TIMER_STOPPED) begin
            if (timer_cnt == '0 && tcfg_periodic)
                timer_cnt <= {tcfg_initval, 2'b0};
            else
                timer_cnt <= timer_cnt - 32'd1;   // one-shot wraps to stopped
        end
    end

    assign tval          = timer_cnt;
    assign timer_expired = (timer_cnt == '0);

    a_idle_hold: assert property (
        @(posedge clk) disable iff (!resetn) (!tcfg_en && !tcfg_wr) |=> $stable(timer_cnt)
    ) else $error("timer counter moved while disabled");

endmodule

// ==== verilog/csr_interrupt.sv ====
// interrupt enables and pending state
`timescale 1ns/10ps

module csr_interrupt (
    input  logic                    clk,
    input  logic                    resetn,
    input  csr_pkg::csr_num_t       csr_num,
    input  logic                    csr_we,
    input  csr_pkg::csr_word_t      csr_wmask,
    input  csr_pkg::csr_word_t      csr_wvalue,
    input  logic [7:0]              hw_int_in,
    input  logic                    ipi_int_in,
    input  logic                    crmd_ie,
    input  logic                    timer_expired,
    output csr_pkg::int_vec_t       ecfg_lie,
    output csr_pkg::int_vec_t       estat_is,
    output logic                    has_int
);

    csr_pkg::csr_word_t ecfg_wr_val;
    csr_pkg::csr_word_t estat_wr_val;
    logic               ticlr_clear;

    assign ecfg_wr_val  = csr_pkg::masked_write({19'b0, ecfg_lie}, csr_wmask, csr_wvalue);
    assign estat_wr_val = csr_pkg::masked_write({19'b0, estat_is}, csr_wmask, csr_wvalue);

    // clear only when bit 0 is both masked in and set
    assign ticlr_clear = csr_we && csr_num == csr_pkg::CSR_TICLR && csr_wmask[0] && csr_wvalue[0];

    always_ff @(posedge clk) begin
        if (!resetn)
            ecfg_lie <= '0;
        else if (csr_we && csr_num == csr_pkg::CSR_ECFG)
            ecfg_lie <= ecfg_wr_val[12:0] & csr_pkg::ECFG_LIE_WRITABLE;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            estat_is <= '0;
        end else begin
            if (csr_we && csr_num == csr_pkg::CSR_ESTAT)
                estat_is[1:0] <= estat_wr_val[1:0];   // software interrupts
            estat_is[9:2] <= hw_int_in;               // sampled every cycle
            estat_is[10]  <= 1'b0;
            if (timer_expired)
                estat_is[csr_pkg::INT_TIMER_BIT] <= 1'b1;
            else if (ticlr_clear)
                estat_is[csr_pkg::INT_TIMER_BIT] <= 1'b0;
            estat_is[csr_pkg::INT_IPI_BIT] <= ipi_int_in;
        end
    end

    assign has_int = crmd_ie && ((estat_is & ecfg_lie) != '0);

endmodule

// ==== verilog/csr_exception_regs.sv ====
// exception state registers
`timescale 1ns/10ps

module csr_exception_regs (
    input  logic                    clk,
    input  logic                    resetn,
    input  csr_pkg::csr_num_t       csr_num,
    input  logic                    csr_we,
    input  csr_pkg::csr_word_t      csr_wmask,
    input  csr_pkg::csr_word_t      csr_wvalue,
    input  logic                    wb_ex,
    input  logic                    ertn_flush,
    input  csr_pkg::ecode_t         wb_ecode,
    input  csr_pkg::esubcode_t      wb_esubcode,
    input  csr_pkg::csr_word_t      wb_pc,
    input  csr_pkg::csr_word_t      wb_vaddr,
    output csr_pkg::plv_t           crmd_plv,
    output logic                    crmd_ie,
    output csr_pkg::plv_t           prmd_pplv,
    output logic                    prmd_pie,
    output csr_pkg::ecode_t         estat_ecode,
    output csr_pkg::esubcode_t      estat_esubcode,
    output csr_pkg::csr_word_t      era_pc,
    output csr_pkg::csr_word_t      badv_vaddr,
    output csr_pkg::eentry_va_t     eentry_va,
    output csr_pkg::csr_word_t      save0,
    output csr_pkg::csr_word_t      save1,
    output csr_pkg::csr_word_t      save2,
    output csr_pkg::csr_word_t      save3
);

    csr_pkg::csr_word_t crmd_wr_val;
    csr_pkg::csr_word_t prmd_wr_val;
    csr_pkg::csr_word_t era_wr_val;
    csr_pkg::csr_word_t eentry_wr_val;
    logic               addr_err;
    logic               fetch_err;

    // field values after a software write in architectural layout
    assign crmd_wr_val   = csr_pkg::masked_write({29'b0, crmd_ie, crmd_plv},
                                                 csr_wmask, csr_wvalue);
    assign prmd_wr_val   = csr_pkg::masked_write({29'b0, prmd_pie, prmd_pplv},
                                                 csr_wmask, csr_wvalue);
    assign era_wr_val    = csr_pkg::masked_write(era_pc, csr_wmask, csr_wvalue);
    assign eentry_wr_val = csr_pkg::masked_write({eentry_va, 6'b0}, csr_wmask, csr_wvalue);

    assign addr_err  = (wb_ecode == csr_pkg::ECODE_ADE) || (wb_ecode == csr_pkg::ECODE_ALE);
    assign fetch_err = (wb_ecode == csr_pkg::ECODE_ADE) && (wb_esubcode == csr_pkg::ESUBCODE_ADEF);

    // crmd plv and ie
    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv <= 2'b0;   // kernel on entry
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_we && csr_num == csr_pkg::CSR_CRMD) begin
            crmd_plv <= crmd_wr_val[1:0];
            crmd_ie  <= crmd_wr_val[2];
        end
    end

    // prmd keeps the interrupted context
    always_ff @(posedge clk) begin
        if (wb_ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (csr_we && csr_num == csr_pkg::CSR_PRMD) begin
            prmd_pplv <= prmd_wr_val[1:0];
            prmd_pie  <= prmd_wr_val[2];
        end
    end

    // cause fields of estat
    always_ff @(posedge clk) begin
        if (!resetn) begin
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end else if (wb_ex) begin
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_ex)
            era_pc <= wb_pc;
        else if (csr_we && csr_num == csr_pkg::CSR_ERA)
            era_pc <= era_wr_val;
    end

    // badv takes the pc on fetch faults and the vaddr on other address errors
    always_ff @(posedge clk) begin
        if (wb_ex && addr_err)
            badv_vaddr <= fetch_err ? wb_pc : wb_vaddr;
    end

    always_ff @(posedge clk) begin
        if (csr_we && csr_num == csr_pkg::CSR_EENTRY)
            eentry_va <= eentry_wr_val[31:6];
    end

    // scratch registers for the handler
    always_ff @(posedge clk) begin
        if (csr_we && csr_num == csr_pkg::CSR_SAVE0)
            save0 <= csr_pkg::masked_write(save0, csr_wmask, csr_wvalue);
        if (csr_we && csr_num == csr_pkg::CSR_SAVE1)
            save1 <= csr_pkg::masked_write(save1, csr_wmask, csr_wvalue);
        if (csr_we && csr_num == csr_pkg::CSR_SAVE2)
            save2 <= csr_pkg::masked_write(save2, csr_wmask, csr_wvalue);
        if (csr_we && csr_num == csr_pkg::CSR_SAVE3)
            save3 <= csr_pkg::masked_write(save3, csr_wmask, csr_wvalue);
    end

    // writeback never retires an exception and an ertn together
    a_no_ex_with_ertn: assert property (
        @(posedge clk) disable iff (!resetn) !(wb_ex && ertn_flush)
    ) else $error("wb_ex and ertn_flush high in the same cycle");

endmodule

// ==== verilog/csr_pkg.sv ====
// csr shared definitions
package csr_pkg;

    // meaningful widths
    typedef logic [13:0] csr_num_t;
    typedef logic [31:0] csr_word_t;
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [12:0] int_vec_t;
    typedef logic [29:0] tcfg_initval_t;
    typedef logic [25:0] eentry_va_t;

    // csr addresses
    localparam csr_num_t CSR_CRMD   = 14'h0;
    localparam csr_num_t CSR_PRMD   = 14'h1;
    localparam csr_num_t CSR_ECFG   = 14'h4;
    localparam csr_num_t CSR_ESTAT  = 14'h5;
    localparam csr_num_t CSR_ERA    = 14'h6;
    localparam csr_num_t CSR_BADV   = 14'h7;
    localparam csr_num_t CSR_EENTRY = 14'hc;
    localparam csr_num_t CSR_SAVE0  = 14'h30;
    localparam csr_num_t CSR_SAVE1  = 14'h31;
    localparam csr_num_t CSR_SAVE2  = 14'h32;
    localparam csr_num_t CSR_SAVE3  = 14'h33;
    localparam csr_num_t CSR_TID    = 14'h40;
    localparam csr_num_t CSR_TCFG   = 14'h41;
    localparam csr_num_t CSR_TVAL   = 14'h42;
    localparam csr_num_t CSR_TICLR  = 14'h44;

    // exception codes that capture a bad address
    localparam ecode_t    ECODE_ADE     = 6'h08;
    localparam ecode_t    ECODE_ALE     = 6'h09;
    localparam esubcode_t ESUBCODE_ADEF = 9'h000;

    // lie bit 10 is reserved
    localparam int_vec_t ECFG_LIE_WRITABLE = 13'h1bff;

    // counter parks here when idle
    localparam csr_word_t TIMER_STOPPED = 32'hffff_ffff;

    // interrupt vector positions
    localparam int INT_TIMER_BIT = 11;
    localparam int INT_IPI_BIT   = 12;

    // new bits where mask is set, old bits elsewhere
    function automatic csr_word_t masked_write(
        input csr_word_t old_value,
        input csr_word_t wmask,
        input csr_word_t wvalue
    );
        return (wmask & wvalue) | (~wmask & old_value);
    endfunction

endpackage
